// File: Bender.yml
package:
  name: pcs_autoneg

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pcs_autoneg_pkg.sv
      - rtl/an_rx_match.sv
      - rtl/an_arbiter.sv
      - rtl/an_mgmt_regs.sv
      - rtl/pcs_autoneg.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/pcs_autoneg_props.sv
      - verification/pcs_autoneg_tb.sv

// File: pcs_autoneg.f
+incdir+rtl
rtl/pcs_autoneg_pkg.sv
rtl/an_rx_match.sv
rtl/an_arbiter.sv
rtl/an_mgmt_regs.sv
rtl/pcs_autoneg.sv
verification/pcs_autoneg_props.sv
verification/pcs_autoneg_tb.sv

// File: rtl/an_arbiter.sv
// auto-negotiation arbitration FSM, base page only
// link timer, next-state logic, registered tx_cfdata / xmit / an_complete
// partner ability capture for register 5
`timescale 1ns/1ps
`include "pcs_autoneg_consts.svh"

module an_arbiter import pcs_autoneg_pkg::*;
#(
    parameter int LINK_TIMER_CYCLES = `AN_LINK_TIMER_DEFAULT
)
(
    input  logic       clk,
    input  logic       rst_,
    input  logic       sync,
    input  rudi_e      rudi,
    input  an_match_t  match,
    input  an_ctrl_t   ctrl,
    output an_stat_t   stat,
    output cfg_word_t  tx_cfdata,
    output xmit_e      xmit,
    output an_state_e  an_state
);

    localparam int        TW       = $clog2(LINK_TIMER_CYCLES + 1);
    localparam cfg_word_t ACK_MASK = cfg_word_t'(1) << `AN_CFG_ACK_BIT;

    an_state_e  state_nxt;
    logic [TW-1:0] link_timer;
    logic       timer_run;
    logic       timer_done;
    logic       link_fault;
    logic       mode_change;
    logic       zero_abi;    // partner sends all-zero ability, i.e. it restarted
    logic       an_complete;
    cfg_word_t  lp_ability;

    ////////////////////////////////////////
    // link timer

    assign timer_run  = (an_state == AN_RESTART) || (an_state == COMPLETE_ACK) ||
                        (an_state == IDLE_DET);
    assign timer_done = (link_timer == TW'(LINK_TIMER_CYCLES));

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
            link_timer <= '0;
        else if (!timer_run || (state_nxt != an_state))
            link_timer <= '0;           // fresh count in every timed state
        else if (!timer_done)
            link_timer <= link_timer + 1'b1;
    end

    ////////////////////////////////////////
    // next state

    assign link_fault  = ctrl.restart || !sync || (rudi == RUDI_INVALID);
    // enable bit flipped under the FSM
    assign mode_change = (an_state != AN_ENABLE) &&
                         (ctrl.an_enable == (an_state == AN_DIS_LINK_OK));
    assign zero_abi    = match.abi_match && match.rx_zero;

    always_comb
    begin
        state_nxt = an_state;
        if (link_fault || mode_change)
            state_nxt = AN_ENABLE;
        else
        begin
            case (an_state)
                AN_ENABLE:      state_nxt = ctrl.an_enable ? AN_RESTART : AN_DIS_LINK_OK;
                AN_RESTART:     if (timer_done) state_nxt = ABILITY_DET;
                ABILITY_DET:    if (match.abi_match && !match.rx_zero) state_nxt = ACK_DET;
                ACK_DET:
                begin
                    if (match.ack_match && match.consist_match)
                        state_nxt = COMPLETE_ACK;
                    else if (match.ack_match || zero_abi)
                        state_nxt = AN_ENABLE;  // inconsistent ack or partner restart
                end
                COMPLETE_ACK:
                begin
                    if (zero_abi)
                        state_nxt = AN_ENABLE;
                    else if (timer_done)
                        state_nxt = IDLE_DET;   // no next page, straight on
                end
                IDLE_DET:       if (timer_done && match.idle_match) state_nxt = LINK_OK;
                LINK_OK:        if (match.abi_match) state_nxt = AN_ENABLE;
                AN_DIS_LINK_OK: state_nxt = AN_DIS_LINK_OK;
                default:        state_nxt = AN_ENABLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
            an_state <= AN_ENABLE;
        else
            an_state <= state_nxt;
    end

    ////////////////////////////////////////
    // outputs, one cycle behind state

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            tx_cfdata   <= '0;
            xmit        <= XMIT_IDLE;
            an_complete <= 1'b0;
        end
        else
        begin
            case (an_state)
                AN_ENABLE:
                begin
                    an_complete <= 1'b0;
                    if (ctrl.an_enable)
                    begin
                        tx_cfdata <= '0;
                        xmit      <= XMIT_CONFIG;
                    end
                    else
                        xmit <= XMIT_IDLE;
                end
                AN_RESTART:
                begin
                    tx_cfdata <= '0;        // break link
                    xmit      <= XMIT_CONFIG;
                end
                AN_DIS_LINK_OK: xmit <= XMIT_DATA;
                ABILITY_DET:    tx_cfdata <= ctrl.adv_ability & ~ACK_MASK; // NP rides along
                ACK_DET:        tx_cfdata <= tx_cfdata | ACK_MASK;
                IDLE_DET:       xmit <= XMIT_IDLE;
                LINK_OK:
                begin
                    xmit        <= XMIT_DATA;
                    an_complete <= 1'b1;
                end
                default:        tx_cfdata <= tx_cfdata;
            endcase
        end
    end

    // partner base page for reg 5, ack bit dropped
    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
            lp_ability <= '0;
        else if (an_state == COMPLETE_ACK)
            lp_ability <= match.rx_word & ~ACK_MASK;
    end

    always_comb
    begin
        stat.an_complete = an_complete;
        stat.link_ok     = (xmit == XMIT_DATA);
        stat.lp_ability  = lp_ability;
    end

endmodule

// File: rtl/an_mgmt_regs.sv
// AXI4-Lite slave for the auto-negotiation management registers
// reg 0 control, reg 1 status (ro), reg 4 advertisement, reg 5 partner ability (ro)
// one transaction at a time, write wins over read
`timescale 1ns/1ps
`include "pcs_autoneg_consts.svh"

module an_mgmt_regs import pcs_autoneg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_,
    input  axil_req_t  mgmt_req,
    input  an_stat_t   stat,
    output axil_rsp_t  mgmt_rsp,
    output an_ctrl_t   ctrl
);

    logic        awready_q;     // also wready
    logic        arready_q;
    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        idle;
    logic        wr_go;
    logic        rd_go;
    logic        wr_hs;
    logic        rd_hs;
    logic [7:0]  wr_addr;
    logic [7:0]  rd_addr;
    logic [15:0] ctrl_reg;
    logic [15:0] adv_reg;
    logic        restart_q;
    logic [15:0] stat_word;
    logic [15:0] rd_word;

    ////////////////////////////////////////
    // handshake

    assign idle  = !(awready_q || arready_q || bvalid_q || rvalid_q);
    assign wr_go = idle && mgmt_req.awvalid && mgmt_req.wvalid;
    assign rd_go = idle && mgmt_req.arvalid && !(mgmt_req.awvalid && mgmt_req.wvalid);
    assign wr_hs = awready_q && mgmt_req.awvalid && mgmt_req.wvalid;
    assign rd_hs = arready_q && mgmt_req.arvalid;

    // word aligned, low address bits dropped
    assign wr_addr = {mgmt_req.awaddr[7:2], 2'b00};
    assign rd_addr = {mgmt_req.araddr[7:2], 2'b00};

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            awready_q <= 1'b0;
            arready_q <= 1'b0;
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
        end
        else
        begin
            awready_q <= wr_go;             // single-cycle pulse
            arready_q <= rd_go;
            if (wr_hs)
                bvalid_q <= 1'b1;
            else if (mgmt_req.bready)
                bvalid_q <= 1'b0;
            if (rd_hs)
                rvalid_q <= 1'b1;
            else if (mgmt_req.rready)
                rvalid_q <= 1'b0;           // held until taken
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_hs)
            rdata_q <= {16'h0000, rd_word};
    end

    ////////////////////////////////////////
    // registers

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            ctrl_reg  <= `AN_CTRL_RESET;
            adv_reg   <= `AN_ADV_RESET;
            restart_q <= 1'b0;
        end
        else
        begin
            restart_q <= wr_hs && (wr_addr == `AN_REG_CTRL) && mgmt_req.wstrb[1] &&
                         mgmt_req.wdata[`AN_CTRL_RESTART_BIT];
            if (wr_hs && (wr_addr == `AN_REG_CTRL))
            begin
                if (mgmt_req.wstrb[0])
                    ctrl_reg[7:0] <= mgmt_req.wdata[7:0];
                if (mgmt_req.wstrb[1])
                begin
                    ctrl_reg[15:8] <= mgmt_req.wdata[15:8];
                    ctrl_reg[`AN_CTRL_RESTART_BIT] <= 1'b0;    // self clearing
                end
            end
            if (wr_hs && (wr_addr == `AN_REG_ADV))
            begin
                if (mgmt_req.wstrb[0])
                    adv_reg[7:0] <= mgmt_req.wdata[7:0];
                if (mgmt_req.wstrb[1])
                    adv_reg[15:8] <= mgmt_req.wdata[15:8];
            end
            // status and partner ability are read-only, writes dropped
        end
    end

    ////////////////////////////////////////
    // read mux

    always_comb
    begin
        stat_word = '0;
        stat_word[`AN_STAT_COMPLETE_BIT] = stat.an_complete;
        stat_word[`AN_STAT_LINK_BIT]     = stat.link_ok;
    end

    always_comb
    begin
        case (rd_addr)
            `AN_REG_CTRL: rd_word = ctrl_reg;
            `AN_REG_STAT: rd_word = stat_word;
            `AN_REG_ADV:  rd_word = adv_reg;
            `AN_REG_LPA:  rd_word = stat.lp_ability;
            default:      rd_word = '0;     // unmapped
        endcase
    end

    always_comb
    begin
        mgmt_rsp.awready = awready_q;
        mgmt_rsp.wready  = awready_q;
        mgmt_rsp.bvalid  = bvalid_q;
        mgmt_rsp.bresp   = 2'b00;   // always OKAY
        mgmt_rsp.arready = arready_q;
        mgmt_rsp.rvalid  = rvalid_q;
        mgmt_rsp.rdata   = rdata_q;
        mgmt_rsp.rresp   = 2'b00;
    end

    always_comb
    begin
        ctrl.an_enable   = ctrl_reg[`AN_CTRL_ENABLE_BIT];
        ctrl.restart     = restart_q;
        ctrl.adv_ability = adv_reg;
    end

endmodule

// File: rtl/an_rx_match.sv
// receive match detectors for auto-negotiation
// ability, acknowledge, consistency and idle match over rx_cfdata / rudi
`timescale 1ns/1ps
`include "pcs_autoneg_consts.svh"

module an_rx_match import pcs_autoneg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_,
    input  cfg_word_t  rx_cfdata,
    input  rudi_e      rudi,
    output an_match_t  match
);

    localparam cfg_word_t ACK_MASK = cfg_word_t'(1) << `AN_CFG_ACK_BIT;

    cfg_word_t lrx_cfdata;   // previous word
    cfg_word_t labi_word;    // captured ability word
    logic [3:0] abi_cnt;
    logic [3:0] ack_cnt;
    logic [2:0] idle_cnt;
    logic       rudi_clr;
    logic       pre_abi;
    logic       pre_ack;
    logic       abi_match;
    logic       ack_match;

    // word compare ignoring ack bit
    assign pre_abi  = ((rx_cfdata ^ lrx_cfdata) & ~ACK_MASK) == '0;
    assign pre_ack  = pre_abi && rx_cfdata[`AN_CFG_ACK_BIT] && lrx_cfdata[`AN_CFG_ACK_BIT];
    assign rudi_clr = (rudi == RUDI_INVALID) || (rudi == RUDI_I);

    assign abi_match = (abi_cnt == 4'(`AN_MATCH_COUNT));
    assign ack_match = (ack_cnt == 4'(`AN_MATCH_COUNT));

    always_ff @(posedge clk or negedge rst_)
    begin
        if (!rst_)
        begin
            lrx_cfdata <= '0;
            abi_cnt    <= '0;
            ack_cnt    <= '0;
            idle_cnt   <= '0;
        end
        else
        begin
            lrx_cfdata <= rx_cfdata;    // latched every cycle

            // ability run, saturates at match
            if (rudi_clr || !pre_abi)
                abi_cnt <= '0;
            else if (!abi_match)
                abi_cnt <= abi_cnt + 4'd1;

            // ack run, same rules plus ack bit in both words
            if (rudi_clr || !pre_ack)
                ack_cnt <= '0;
            else if (!ack_match)
                ack_cnt <= ack_cnt + 4'd1;

            if (rudi != RUDI_I)
                idle_cnt <= '0;
            else if (idle_cnt < 3'(`AN_IDLE_COUNT))
                idle_cnt <= idle_cnt + 3'd1;
        end
    end

    // follows the word while ability matches; frozen on a word change
    always_ff @(posedge clk)
    begin
        if (abi_match)
            labi_word <= lrx_cfdata;
    end

    always_comb
    begin
        match.abi_match     = abi_match;
        match.ack_match     = ack_match;
        match.consist_match = ack_match && (lrx_cfdata == labi_word);
        match.idle_match    = (idle_cnt == 3'(`AN_IDLE_COUNT));
        match.rx_zero       = (lrx_cfdata == '0);
        match.rx_word       = lrx_cfdata;
    end

endmodule

// File: rtl/pcs_autoneg.sv
// 1000BASE-X PCS auto-negotiation top
// rx match detectors -> arbitration FSM, AXI4-Lite management registers
`timescale 1ns/1ps
`include "pcs_autoneg_consts.svh"

module pcs_autoneg import pcs_autoneg_pkg::*;
#(
    parameter int LINK_TIMER_CYCLES = `AN_LINK_TIMER_DEFAULT
)
(
    input  logic       clk,
    input  logic       rst_,
    input  logic       sync,
    input  rudi_e      rudi,
    input  cfg_word_t  rx_cfdata,
    input  axil_req_t  mgmt_req,
    output axil_rsp_t  mgmt_rsp,
    output cfg_word_t  tx_cfdata,
    output xmit_e      xmit,
    output an_state_e  an_state,
    output logic       an_complete
);

    an_match_t match;
    an_ctrl_t  ctrl;
    an_stat_t  stat;

    an_rx_match u_rx_match (
        .clk       (clk),
        .rst_      (rst_),
        .rx_cfdata (rx_cfdata),
        .rudi      (rudi),
        .match     (match)
    );

    an_arbiter #(.LINK_TIMER_CYCLES(LINK_TIMER_CYCLES)) u_arbiter (
        .clk       (clk),
        .rst_      (rst_),
        .sync      (sync),
        .rudi      (rudi),
        .match     (match),
        .ctrl      (ctrl),
        .stat      (stat),
        .tx_cfdata (tx_cfdata),
        .xmit      (xmit),
        .an_state  (an_state)
    );

    an_mgmt_regs u_mgmt_regs (
        .clk       (clk),
        .rst_      (rst_),
        .mgmt_req  (mgmt_req),
        .stat      (stat),
        .mgmt_rsp  (mgmt_rsp),
        .ctrl      (ctrl)
    );

    assign an_complete = stat.an_complete;

endmodule

// File: rtl/pcs_autoneg_consts.svh
// shared constants for the 1000BASE-X auto-negotiation block
// link timer, match run lengths, register map, reset values, bit positions
`ifndef PCS_AUTONEG_CONSTS_SVH
`define PCS_AUTONEG_CONSTS_SVH

// timers and run lengths, in clk cycles
`define AN_LINK_TIMER_DEFAULT   1250000 // 10 ms at 125 MHz
`define AN_MATCH_COUNT          11      // equal comparisons, i.e. 12 words
`define AN_IDLE_COUNT           5       // consecutive /I/

// management register map, byte addresses
`define AN_REG_CTRL             8'h00   // reg 0
`define AN_REG_STAT             8'h04   // reg 1
`define AN_REG_ADV              8'h10   // reg 4
`define AN_REG_LPA              8'h14   // reg 5

// reset values
`define AN_CTRL_RESET           16'h1140 // AN enable, full duplex, 1 Gb/s
`define AN_ADV_RESET            16'h0020 // FD only

// bit positions
`define AN_CTRL_ENABLE_BIT      12
`define AN_CTRL_RESTART_BIT     9
`define AN_STAT_LINK_BIT        2
`define AN_STAT_COMPLETE_BIT    5
`define AN_CFG_ACK_BIT          14
`define AN_CFG_NP_BIT           15

`endif

// File: rtl/pcs_autoneg_pkg.sv
// types for the auto-negotiation block
// arbitration states, xmit and rudi codes
// config word, AXI4-Lite request/response, match, control and status bundles
package pcs_autoneg_pkg;

    // arbitration states, code 5 was next-page wait and stays unused
    typedef enum logic [3:0] {
        AN_ENABLE      = 4'd0,
        AN_RESTART     = 4'd1,
        AN_DIS_LINK_OK = 4'd2,
        ABILITY_DET    = 4'd3,
        ACK_DET        = 4'd4,
        COMPLETE_ACK   = 4'd6,
        IDLE_DET       = 4'd7,
        LINK_OK        = 4'd8
    } an_state_e;

    typedef enum logic [1:0] {
        XMIT_IDLE   = 2'd0,
        XMIT_CONFIG = 2'd1,
        XMIT_DATA   = 2'd2
    } xmit_e;

    // receive indication from the PCS sync/decode path
    typedef enum logic [1:0] {
        RUDI_NONE    = 2'b00,
        RUDI_C       = 2'b01,   // /C/ ordered set
        RUDI_I       = 2'b10,   // /I/ ordered set
        RUDI_INVALID = 2'b11
    } rudi_e;

    typedef logic [15:0] cfg_word_t; // tx/rx config register

    ////////////////////////////////////////
    // AXI4-Lite management port

    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    ////////////////////////////////////////
    // internal bundles

    typedef struct packed {
        logic      abi_match;
        logic      ack_match;
        logic      consist_match;
        logic      idle_match;
        logic      rx_zero;     // latched word all zero
        cfg_word_t rx_word;     // latched word
    } an_match_t;

    typedef struct packed {
        logic      an_enable;
        logic      restart;     // one-cycle pulse
        cfg_word_t adv_ability;
    } an_ctrl_t;

    typedef struct packed {
        logic      an_complete;
        logic      link_ok;
        cfg_word_t lp_ability;
    } an_stat_t;

endpackage

// File: verification/pcs_autoneg_props.sv
// concurrent checks on the arbitration FSM, bound to an_arbiter
// an_complete only in or just after LINK_OK
// no data transmission during ability detect
// fast return to AN_ENABLE on invalid receive data
`timescale 1ns/1ps

module pcs_autoneg_props import pcs_autoneg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_,
    input  rudi_e     rudi,
    input  an_state_e an_state,
    input  xmit_e     xmit,
    input  logic      an_complete
);

    int unsigned prop_fails = 0;    // failure count

    // flag is registered, so it may trail the state by one cycle
    complete_in_link_ok: assert property (@(posedge clk) disable iff (!rst_)
        an_complete |-> (an_state == LINK_OK) || ($past(an_state) == LINK_OK))
    else
    begin
        $error("an_complete high outside LINK_OK");
        prop_fails++;
    end

    no_data_in_ability: assert property (@(posedge clk) disable iff (!rst_)
        (an_state == ABILITY_DET) |-> (xmit != XMIT_DATA))
    else
    begin
        $error("xmit DATA during ABILITY_DET");
        prop_fails++;
    end

    // state reg one cycle, allow one more
    invalid_restarts: assert property (@(posedge clk) disable iff (!rst_)
        (rudi == RUDI_INVALID) |-> ##[1:2] (an_state == AN_ENABLE))
    else
    begin
        $error("no return to AN_ENABLE after invalid receive data");
        prop_fails++;
    end

endmodule

// File: verification/pcs_autoneg_tb.sv
// testbench for the auto-negotiation top
// clock, reset, link-partner model, AXI4-Lite read and write
// directed tests: reset values, registers, negotiation, restart, link fault,
// inconsistent acknowledge, AN disabled
`timescale 1ns/1ps
`include "pcs_autoneg_consts.svh"

module pcs_autoneg_tb import pcs_autoneg_pkg::*;
();

    localparam int        LINK_TIMER = 40;
    localparam cfg_word_t ACK        = cfg_word_t'(1) << `AN_CFG_ACK_BIT;

    typedef enum int {COND_STATE, COND_TX, COND_XMIT, COND_COMPLETE} cond_e;

    logic       clk;
    logic       rst_;
    logic       sync;
    rudi_e      rudi;
    cfg_word_t  rx_cfdata;
    axil_req_t  mgmt_req;
    axil_rsp_t  mgmt_rsp;
    cfg_word_t  tx_cfdata;
    xmit_e      xmit;
    an_state_e  an_state;
    logic       an_complete;

    integer     seed;
    int         errors;
    int         checks;
    int         tests;
    int         total;
    cfg_word_t  adv_word;   // our advertisement, mirrors reg 4
    cfg_word_t  lp_word;    // partner base page, ack clear

    pcs_autoneg #(.LINK_TIMER_CYCLES(LINK_TIMER)) uut (
        .clk         (clk),
        .rst_        (rst_),
        .sync        (sync),
        .rudi        (rudi),
        .rx_cfdata   (rx_cfdata),
        .mgmt_req    (mgmt_req),
        .mgmt_rsp    (mgmt_rsp),
        .tx_cfdata   (tx_cfdata),
        .xmit        (xmit),
        .an_state    (an_state),
        .an_complete (an_complete)
    );

    bind an_arbiter pcs_autoneg_props u_props (
        .clk         (clk),
        .rst_        (rst_),
        .rudi        (rudi),
        .an_state    (an_state),
        .xmit        (xmit),
        .an_complete (stat.an_complete)
    );

    always #50 clk = ~clk;  // 100 ns period

    ////////////////////////////////////////
    // checking and waiting

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout waiting for %s", what);
        errors++;
    endtask

    function automatic bit reached(input cond_e kind, input logic [15:0] val);
        case (kind)
            COND_STATE: return an_state == an_state_e'(val[3:0]);
            COND_TX:    return tx_cfdata == val;
            COND_XMIT:  return xmit == xmit_e'(val[1:0]);
            default:    return an_complete == val[0];
        endcase
    endfunction

    // polls on the falling edge, outputs settled there
    task automatic wait_until(input cond_e kind, input logic [15:0] val, input int limit,
                              input string what);
        int n;
        n = 0;
        while (!reached(kind, val) && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!reached(kind, val))
            report_timeout(what);
    endtask

    task automatic finish_test(input string name, input int start);
        tests++;
        $display("test %-14s done, %0d errors", name, errors - start);
    endtask

    ////////////////////////////////////////
    // AXI4-Lite master

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(negedge clk);
        mgmt_req.awaddr  = addr;
        mgmt_req.awvalid = 1'b1;
        mgmt_req.wdata   = data;
        mgmt_req.wstrb   = 4'hf;
        mgmt_req.wvalid  = 1'b1;
        mgmt_req.bready  = 1'b1;
        n = 0;
        while (!mgmt_rsp.awready && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (!mgmt_rsp.awready)
            report_timeout("awready on write");
        else
            check_eq("wready", 32'h1, mgmt_rsp.wready);   // raised with awready
        @(negedge clk);             // handshake edge has passed
        mgmt_req.awvalid = 1'b0;
        mgmt_req.wvalid  = 1'b0;
        n = 0;
        while (!mgmt_rsp.bvalid && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (!mgmt_rsp.bvalid)
            report_timeout("bvalid on write");
        else
            check_eq("bresp", 32'h0, mgmt_rsp.bresp);
        @(negedge clk);
        mgmt_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        @(negedge clk);
        mgmt_req.araddr  = addr;
        mgmt_req.arvalid = 1'b1;
        mgmt_req.rready  = 1'b1;
        n = 0;
        while (!mgmt_rsp.arready && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (!mgmt_rsp.arready)
            report_timeout("arready on read");
        @(negedge clk);
        mgmt_req.arvalid = 1'b0;
        n = 0;
        while (!mgmt_rsp.rvalid && n < 20)
        begin
            @(negedge clk);
            n++;
        end
        if (!mgmt_rsp.rvalid)
            report_timeout("rvalid on read");
        else
            check_eq("rresp", 32'h0, mgmt_rsp.rresp);
        data = mgmt_rsp.rdata;      // held while rvalid
        @(negedge clk);
        mgmt_req.rready = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        axi_read(addr, got);
        check_eq($sformatf("rdata[%02h]", addr), exp, got);
    endtask

    ////////////////////////////////////////
    // link partner

    task automatic partner_send(input cfg_word_t w);
        @(negedge clk);
        rx_cfdata = w;      // repeats until changed
        rudi      = RUDI_C;
    endtask

    task automatic partner_idle();
        @(negedge clk);
        rx_cfdata = '0;
        rudi      = RUDI_I;
    endtask

    function automatic cfg_word_t random_ability();
        cfg_word_t w;
        w = cfg_word_t'($random(seed));
        w[`AN_CFG_ACK_BIT] = 1'b0;
        if (w == '0)
            w = 16'h0020;   // zero page would mean restart
        return w;
    endfunction

    // ability, ack, idles; tx side checked on the way
    task automatic bring_up_link(input cfg_word_t w);
        wait_until(COND_TX, adv_word & ~ACK, 200, "advertisement on tx_cfdata");
        check_eq("tx_cfdata", adv_word & ~ACK, tx_cfdata);
        partner_send(w);
        wait_until(COND_STATE, ACK_DET, 100, "state ACK_DET");
        wait_until(COND_TX, adv_word | ACK, 10, "acknowledge on tx_cfdata");
        check_eq("tx_cfdata", adv_word | ACK, tx_cfdata);
        partner_send(w | ACK);
        wait_until(COND_STATE, IDLE_DET, 200, "state IDLE_DET");
        partner_idle();
        wait_until(COND_COMPLETE, 16'h1, 200, "an_complete high");
        check_eq("an_complete", 32'h1, an_complete);
        check_eq("xmit", XMIT_DATA, xmit);
    endtask

    ////////////////////////////////////////
    // directed tests

    // outputs still at their reset values
    task automatic reset_outputs();
        int start;
        start = errors;
        check_eq("an_state", AN_ENABLE, an_state);
        check_eq("xmit", XMIT_IDLE, xmit);
        check_eq("tx_cfdata", 32'h0, tx_cfdata);
        check_eq("an_complete", 32'h0, an_complete);
        check_eq("awready", 32'h0, mgmt_rsp.awready);
        check_eq("wready", 32'h0, mgmt_rsp.wready);
        check_eq("bvalid", 32'h0, mgmt_rsp.bvalid);
        check_eq("arready", 32'h0, mgmt_rsp.arready);
        check_eq("rvalid", 32'h0, mgmt_rsp.rvalid);
        finish_test("reset", start);
    endtask

    task automatic register_access();
        int start;
        start = errors;
        read_check(`AN_REG_CTRL, 32'h1140);
        read_check(`AN_REG_STAT, 32'h0000);
        read_check(`AN_REG_ADV, 32'h0020);
        read_check(8'h08, 32'h0000);                // unmapped
        adv_word = 16'h01a0;                        // FD + pause bits
        axi_write(`AN_REG_ADV, {16'h0000, adv_word});
        read_check(`AN_REG_ADV, {16'h0000, adv_word});
        axi_write(`AN_REG_STAT, 32'h0000ffff);      // read-only
        read_check(`AN_REG_STAT, 32'h0000);
        read_check(`AN_REG_CTRL, 32'h1140);
        read_check(`AN_REG_ADV, {16'h0000, adv_word});
        finish_test("registers", start);
    endtask

    task automatic full_negotiation();
        int start;
        start = errors;
        lp_word = random_ability();
        bring_up_link(lp_word);
        read_check(`AN_REG_STAT, 32'h0024);         // complete + link
        read_check(`AN_REG_LPA, {16'h0000, lp_word}); // partner page, no ack bit
        finish_test("negotiation", start);
    endtask

    task automatic restart_link();
        int start;
        start = errors;
        axi_write(`AN_REG_CTRL, 32'h1340);          // restart bit set
        wait_until(COND_COMPLETE, 16'h0, 10, "an_complete low after restart");
        check_eq("xmit", XMIT_CONFIG, xmit);
        check_eq("tx_cfdata", 32'h0, tx_cfdata);
        read_check(`AN_REG_CTRL, 32'h1140);         // restart self clears
        finish_test("restart", start);
    endtask

    task automatic link_fault_drop();
        int start;
        start = errors;
        bring_up_link(lp_word);
        @(negedge clk);
        rudi = RUDI_INVALID;                        // held until flag drops
        wait_until(COND_COMPLETE, 16'h0, 10, "an_complete low after invalid data");
        check_eq("an_state", AN_ENABLE, an_state);
        partner_idle();
        finish_test("link_fault", start);
    endtask

    task automatic inconsistent_ack();
        int        start;
        cfg_word_t first;
        cfg_word_t second;
        start  = errors;
        first  = random_ability();
        second = random_ability();
        if (second == first)
            second = first ^ 16'h0020;
        if (second == '0)
            second = 16'h0040;
        partner_send(first);
        wait_until(COND_STATE, ACK_DET, 200, "state ACK_DET");
        partner_send(second | ACK);                 // ack of a different page
        wait_until(COND_STATE, AN_ENABLE, 100, "return to AN_ENABLE");
        check_eq("an_complete", 32'h0, an_complete);
        partner_idle();
        finish_test("inconsistent", start);
    endtask

    task automatic an_disabled_mode();
        int start;
        start = errors;
        axi_write(`AN_REG_CTRL, 32'h0140);          // enable bit clear
        wait_until(COND_XMIT, XMIT_DATA, 20, "xmit DATA with AN disabled");
        check_eq("an_complete", 32'h0, an_complete);
        check_eq("an_state", AN_DIS_LINK_OK, an_state);
        read_check(`AN_REG_STAT, 32'h0004);         // link only
        finish_test("an_disabled", start);
    endtask

    ////////////////////////////////////////
    // main sequence

    initial
    begin
        clk       = 1'b0;
        rst_      = 1'b0;
        sync      = 1'b1;
        rudi      = RUDI_I;
        rx_cfdata = '0;
        mgmt_req  = '0;
        seed      = 32'h73c1288a;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        adv_word  = 16'h0020;
        lp_word   = '0;
        repeat (16) @(negedge clk);
        rst_ = 1'b1;

        reset_outputs();
        register_access();
        full_negotiation();
        restart_link();
        link_fault_drop();
        inconsistent_ack();
        an_disabled_mode();

        total = errors + uut.u_arbiter.u_props.prop_fails;
        $display("tests %0d, checks %0d, check errors %0d, property failures %0d",
                 tests, checks, errors, uut.u_arbiter.u_props.prop_fails);
        if (total == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
